/* hdl/openadc_pkg.sv */
package openadc_pkg;

   // register bus payload
   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_byte_t;

   // edge count per window, also used for the change limit
   typedef logic [31:0] freq_t;

   localparam int freq_bytes = $bits(freq_t) / 8;

   // which LED pattern is shown
   typedef enum logic [1:0] {
      led_sel_normal         = 2'b00, // heartbeat on armed, capture off
      led_sel_heartbeat_pair = 2'b01, // heartbeat and its inverse
      led_sel_flash          = 2'b10, // flash pattern on both
      led_sel_change         = 2'b11  // heartbeat plus change flag
   } led_sel_t;

   // register map
   localparam reg_addr_t addr_status    = 8'h01; // read only
   localparam reg_addr_t addr_gain      = 8'h02;
   localparam reg_addr_t addr_settings  = 8'h03;
   localparam reg_addr_t addr_ext_freq  = 8'h04; // read only, 4 bytes
   localparam reg_addr_t addr_ext_limit = 8'h05; // 4 bytes

   // status byte layout
   localparam int status_change_bit = 0;
   localparam int status_valid_bit  = 1;

   // settings byte layout, led select sits in bits 1:0
   localparam int settings_src_bit = 2; // 1 = generated clock
   localparam int settings_dis_bit = 3; // monitor disable

endpackage

/* hdl/clk_monitor_if.sv */
`timescale 1ns/10ps

interface clk_monitor_if;

   // control from the register bank
   logic                  measure_src;
   logic                  monitor_disable;
   openadc_pkg::freq_t    limit;

   // results from the clock monitor
   openadc_pkg::freq_t    frequency;
   logic                  freq_valid;
   logic                  change;

   modport regs_mp (
      output measure_src, monitor_disable, limit,
      input  frequency, freq_valid, change
   );

   modport monitor_mp (
      input  measure_src, monitor_disable, limit,
      output frequency, freq_valid, change
   );

endinterface

/* hdl/openadc_regs.sv */
`timescale 1ns/10ps

module openadc_regs #(
   parameter int bytecnt_size = 7
) (
   input  logic                        clk_usb,
   input  logic                        reset,

   input  openadc_pkg::reg_addr_t      reg_address_i,
   input  logic [bytecnt_size-1:0]     reg_bytecnt_i,
   input  openadc_pkg::reg_byte_t      reg_datai_i,
   input  logic                        reg_read_i,
   input  logic                        reg_write_i,
   output openadc_pkg::reg_byte_t      reg_datao_o,

   clk_monitor_if.regs_mp              mon,

   output openadc_pkg::led_sel_t       led_select_o,
   output logic                        amp_gain_o
);

   openadc_pkg::reg_byte_t gain_r;
   openadc_pkg::reg_byte_t settings_r;
   openadc_pkg::freq_t     limit_r;

   logic       first_byte; // byte count is zero
   logic       word_byte;  // byte count inside a 32-bit word
   logic [1:0] byte_idx;
   logic [8:0] pwm_acc;    // bit 8 is the carry out

   assign first_byte = (reg_bytecnt_i == '0);
   assign word_byte  = (reg_bytecnt_i < bytecnt_size'(openadc_pkg::freq_bytes));
   assign byte_idx   = reg_bytecnt_i[1:0];

   // byte writes, read-only addresses simply fall through
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_r     <= '0;
         settings_r <= '0;
         limit_r    <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            openadc_pkg::addr_gain: begin
               if (first_byte)
                  gain_r <= reg_datai_i;
            end
            openadc_pkg::addr_settings: begin
               if (first_byte)
                  settings_r <= reg_datai_i;
            end
            openadc_pkg::addr_ext_limit: begin
               if (word_byte)
                  limit_r[8*byte_idx +: 8] <= reg_datai_i;
            end
            default: ;
         endcase
      end
   end

   // read data, zero when idle or unmapped
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            openadc_pkg::addr_status: begin
               if (first_byte) begin
                  reg_datao_o[openadc_pkg::status_change_bit] = mon.change;
                  reg_datao_o[openadc_pkg::status_valid_bit]  = mon.freq_valid;
               end
            end
            openadc_pkg::addr_gain: begin
               if (first_byte)
                  reg_datao_o = gain_r;
            end
            openadc_pkg::addr_settings: begin
               if (first_byte)
                  reg_datao_o = settings_r;
            end
            openadc_pkg::addr_ext_freq: begin
               if (word_byte)
                  reg_datao_o = mon.frequency[8*byte_idx +: 8];
            end
            openadc_pkg::addr_ext_limit: begin
               if (word_byte)
                  reg_datao_o = limit_r[8*byte_idx +: 8];
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

   // controls decoded from the settings byte
   assign led_select_o        = openadc_pkg::led_sel_t'(settings_r[1:0]);
   assign mon.measure_src     = settings_r[openadc_pkg::settings_src_bit];
   assign mon.monitor_disable = settings_r[openadc_pkg::settings_dis_bit];
   assign mon.limit           = limit_r;

   // gain PWM: carry fires gain times out of every 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_r};
   end

   assign amp_gain_o = pwm_acc[8];

endmodule

/* hdl/status_leds.sv */
`timescale 1ns/10ps

module status_leds #(
   parameter int window_log2 = 23
) (
   input  logic                        clk_usb,
   input  logic                        reset,

   input  openadc_pkg::led_sel_t       led_select_i,
   input  logic                        change_i,

   output logic                        measure_tick_o,
   output logic                        led_armed_o,
   output logic                        led_capture_o
);

   // tick bit, flash bit, heartbeat bit and the top bit above them
   localparam int cnt_width = window_log2 + 3;

   logic [cnt_width-1:0] timebase;
   logic                 tick_bit_r; // previous value of the tick bit
   logic                 flash_r;
   logic                 heartbeat;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timebase       <= '0;
         tick_bit_r     <= 1'b0;
         measure_tick_o <= 1'b0;
      end else begin
         timebase       <= timebase + cnt_width'(1);
         tick_bit_r     <= timebase[window_log2-1];
         measure_tick_o <= timebase[window_log2-1] & ~tick_bit_r; // rising edge only
      end
   end

   // flash pattern only moves during the upper half of the counter
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_r <= 1'b0;
      else if (timebase[cnt_width-1])
         flash_r <= ~timebase[window_log2];
   end

   assign heartbeat = timebase[window_log2+1];

   always_comb begin
      if (change_i) begin
         led_armed_o   = flash_r; // a detected change overrides the selection
         led_capture_o = flash_r;
      end else begin
         case (led_select_i)
            openadc_pkg::led_sel_heartbeat_pair: begin
               led_armed_o   = heartbeat;
               led_capture_o = ~heartbeat;
            end
            openadc_pkg::led_sel_flash: begin
               led_armed_o   = flash_r;
               led_capture_o = flash_r;
            end
            openadc_pkg::led_sel_change: begin
               led_armed_o   = heartbeat;
               led_capture_o = change_i;
            end
            default: begin
               led_armed_o   = heartbeat;
               led_capture_o = 1'b0;
            end
         endcase
      end
   end

endmodule

/* hdl/clk_monitor.sv */
`timescale 1ns/10ps

module clk_monitor (
   input  logic                        clk_usb,
   input  logic                        reset,

   input  logic                        dut_clk_i,
   input  logic                        clkgen_i,
   input  logic                        measure_tick_i,

   clk_monitor_if.monitor_mp           mon,

   output logic                        change_o
);

   logic                  meas_clk;   // selected clock, sampled as data
   logic [1:0]            sync_r;
   logic                  sync_d;
   logic                  rise;
   openadc_pkg::freq_t    count_r;
   openadc_pkg::freq_t    freq_r;
   openadc_pkg::freq_t    diff;
   logic                  valid_r;
   logic                  change_r;

   assign meas_clk = mon.measure_src ? clkgen_i : dut_clk_i;

   // two-stage synchronizer plus one stage for edge detection
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_r <= '0;
         sync_d <= 1'b0;
      end else begin
         sync_r <= {sync_r[0], meas_clk};
         sync_d <= sync_r[1];
      end
   end

   assign rise = sync_r[1] & ~sync_d;

   // absolute difference between last window and the one just closing
   assign diff = (freq_r > count_r) ? (freq_r - count_r) : (count_r - freq_r);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_r <= '0;
         freq_r  <= '0;
         valid_r <= 1'b0;
      end else if (measure_tick_i) begin
         freq_r  <= count_r;
         count_r <= openadc_pkg::freq_t'(rise); // an edge on the tick opens the new window
         valid_r <= 1'b1;
      end else if (rise) begin
         count_r <= count_r + openadc_pkg::freq_t'(1);
      end
   end

   // sticky change flag, held clear while disabled
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_r <= 1'b0;
      else if (mon.monitor_disable)
         change_r <= 1'b0;
      else if (measure_tick_i && (freq_r != '0) && (count_r != '0) && (diff > mon.limit))
         change_r <= 1'b1;
   end

   assign mon.frequency  = freq_r;
   assign mon.freq_valid = valid_r;
   assign mon.change     = change_r;
   assign change_o       = change_r;

endmodule

/* hdl/openadc_top.sv */
`timescale 1ns/10ps

module openadc_top #(
   parameter int bytecnt_size = 7,
   parameter int window_log2  = 23
) (
   input  logic                        clk_usb,
   input  logic                        reset,

   // host register bus
   input  openadc_pkg::reg_addr_t      reg_address_i,
   input  logic [bytecnt_size-1:0]     reg_bytecnt_i,
   input  openadc_pkg::reg_byte_t      reg_datai_i,
   input  logic                        reg_read_i,
   input  logic                        reg_write_i,
   output openadc_pkg::reg_byte_t      reg_datao_o,

   // clocks to be measured, sampled in clk_usb
   input  logic                        dut_clk_i,
   input  logic                        clkgen_i,

   output logic                        amp_gain_o,
   output logic                        led_armed_o,
   output logic                        led_capture_o
);

   logic                  measure_tick;
   logic                  change;
   openadc_pkg::led_sel_t led_select;

   clk_monitor_if mon_if ();

   openadc_regs #(
      .bytecnt_size (bytecnt_size)
   ) regs_i (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .reg_datao_o   (reg_datao_o),
      .mon           (mon_if.regs_mp),
      .led_select_o  (led_select),
      .amp_gain_o    (amp_gain_o)
   );

   status_leds #(
      .window_log2 (window_log2)
   ) leds_i (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .led_select_i   (led_select),
      .change_i       (change),
      .measure_tick_o (measure_tick),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

   clk_monitor monitor_i (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .dut_clk_i      (dut_clk_i),
      .clkgen_i       (clkgen_i),
      .measure_tick_i (measure_tick),
      .mon            (mon_if.monitor_mp),
      .change_o       (change)
   );

endmodule

/* test/openadc_tb_tasks.svh */
task automatic reg_write_byte(input openadc_pkg::reg_addr_t addr, input int cnt,
                              input openadc_pkg::reg_byte_t data);
   @(posedge clk_usb);
   #2;
   reg_address_i = addr;
   reg_bytecnt_i = bytecnt_size'(cnt);
   reg_datai_i   = data;
   reg_write_i   = 1'b1;
   @(posedge clk_usb); // write lands on this edge
   #2;
   reg_write_i   = 1'b0;
endtask

task automatic reg_read_byte(input openadc_pkg::reg_addr_t addr, input int cnt,
                             output openadc_pkg::reg_byte_t data);
   @(posedge clk_usb);
   #2;
   reg_address_i = addr;
   reg_bytecnt_i = bytecnt_size'(cnt);
   reg_read_i    = 1'b1;
   @(negedge clk_usb);
   data = reg_datao_o; // combinational read data, settled by now
   @(posedge clk_usb);
   #2;
   reg_read_i    = 1'b0;
endtask

task automatic write_limit(input openadc_pkg::freq_t value);
   for (int b = 0; b < 4; b++)
      reg_write_byte(openadc_pkg::addr_ext_limit, b, value[8*b +: 8]);
endtask

task automatic read_freq(output openadc_pkg::freq_t freq);
   openadc_pkg::reg_byte_t data;
   for (int b = 0; b < 4; b++) begin
      reg_read_byte(openadc_pkg::addr_ext_freq, b, data);
      freq[8*b +: 8] = data; // byte 0 is the least significant
   end
endtask

task automatic read_status_bit(input int bit_pos, output logic value);
   openadc_pkg::reg_byte_t data;
   reg_read_byte(openadc_pkg::addr_status, 0, data);
   value = data[bit_pos];
endtask

// period change takes effect away from the generator's drive point
task automatic set_periods(input int dut_p, input int gen_p);
   @(negedge clk_usb);
   dut_period = dut_p;
   gen_period = gen_p;
endtask

task automatic wait_ticks(input int n);
   repeat (n) begin
      @(negedge clk_usb);
      while (dut_i.measure_tick !== 1'b1)
         @(negedge clk_usb);
   end
endtask

function automatic openadc_pkg::reg_byte_t random_byte();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state[31:24]; // upper bits have the longest period
endfunction

task automatic check_byte(input string name, input openadc_pkg::reg_byte_t exp,
                          input openadc_pkg::reg_byte_t act);
   if (act !== exp) begin
      $display("Fail %s: expected 0x%02h, got 0x%02h", name, exp, act);
      report_failure();
   end
endtask

task automatic check_freq(input string name, input openadc_pkg::freq_t exp,
                          input openadc_pkg::freq_t act);
   if ($isunknown(act) || (act > exp + 1) || (act + 1 < exp)) begin
      $display("Fail %s: expected 0x%08h +-1, got 0x%08h", name, exp, act);
      report_failure();
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
      report_failure();
   end
endtask

task automatic check_count(input string name, input int exp, input int act);
   if (act != exp) begin
      $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
      report_failure();
   end
endtask

task automatic test_reset_readback();
   openadc_pkg::reg_byte_t data;
   openadc_pkg::reg_byte_t wr;
   openadc_pkg::reg_byte_t limit_bytes[4];
   reg_read_byte(openadc_pkg::addr_status, 0, data);
   check_byte("status", 8'h00, data);
   reg_read_byte(openadc_pkg::addr_gain, 0, data);
   check_byte("gain", 8'h00, data);
   reg_read_byte(openadc_pkg::addr_settings, 0, data);
   check_byte("settings", 8'h00, data);
   for (int b = 0; b < 4; b++) begin
      reg_read_byte(openadc_pkg::addr_ext_freq, b, data);
      check_byte("ext_freq byte", 8'h00, data);
      reg_read_byte(openadc_pkg::addr_ext_limit, b, data);
      check_byte("ext_limit byte", 8'h00, data);
   end
   wr = random_byte();
   reg_write_byte(openadc_pkg::addr_gain, 0, wr);
   reg_read_byte(openadc_pkg::addr_gain, 0, data);
   check_byte("gain", wr, data);
   wr = random_byte();
   reg_write_byte(openadc_pkg::addr_settings, 0, wr);
   reg_read_byte(openadc_pkg::addr_settings, 0, data);
   check_byte("settings", wr, data);
   // all limit bytes first so a stray byte lane shows up on readback
   for (int b = 0; b < 4; b++) begin
      limit_bytes[b] = random_byte();
      reg_write_byte(openadc_pkg::addr_ext_limit, b, limit_bytes[b]);
   end
   for (int b = 0; b < 4; b++) begin
      reg_read_byte(openadc_pkg::addr_ext_limit, b, data);
      check_byte("ext_limit byte", limit_bytes[b], data);
   end
   // read-only registers ignore writes, no clock is running yet
   reg_write_byte(openadc_pkg::addr_status, 0, random_byte());
   reg_read_byte(openadc_pkg::addr_status, 0, data);
   check_byte("status", 8'h00, data);
   for (int b = 0; b < 4; b++) begin
      reg_write_byte(openadc_pkg::addr_ext_freq, b, random_byte());
      reg_read_byte(openadc_pkg::addr_ext_freq, b, data);
      check_byte("ext_freq byte", 8'h00, data);
   end
endtask

task automatic test_gain_pwm();
   openadc_pkg::reg_byte_t gain;
   int highs;
   for (int n = 0; n < 6; n++) begin
      gain = (n == 0) ? 8'h00 : (n == 1) ? 8'hff : random_byte();
      reg_write_byte(openadc_pkg::addr_gain, 0, gain);
      @(posedge clk_usb); // first accumulation with the new gain
      highs = 0;
      repeat (256) begin
         @(negedge clk_usb);
         if (amp_gain_o)
            highs++;
      end
      check_count("amp_gain_o high cycles", gain, highs);
   end
endtask

task automatic test_freq_measure();
   openadc_pkg::freq_t freq;
   logic valid;
   write_limit('1); // keep the change flag out of the way
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h00);
   for (int p = 8; p <= 12; p += 4) begin
      set_periods(p, 0);
      wait_ticks(2); // second window is all at the new period
      read_freq(freq);
      check_freq("ext_freq", window_cycles / p, freq);
      read_status_bit(openadc_pkg::status_valid_bit, valid);
      check_bit("freq_valid", 1'b1, valid);
   end
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h04); // generated clock
   set_periods(12, 16);
   wait_ticks(2);
   read_freq(freq);
   check_freq("ext_freq", window_cycles / 16, freq);
endtask

task automatic test_change_detect();
   logic change;
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h00);
   write_limit(200);
   set_periods(8, 0);
   wait_ticks(2);
   set_periods(16, 0); // 128 down to 64 stays inside the limit
   wait_ticks(3);
   read_status_bit(openadc_pkg::status_change_bit, change);
   check_bit("change", 1'b0, change);
   set_periods(8, 0);
   wait_ticks(2);
   write_limit(10);
   set_periods(16, 0);
   wait_ticks(2);
   read_status_bit(openadc_pkg::status_change_bit, change);
   check_bit("change", 1'b1, change);
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h08); // monitor disable
   read_status_bit(openadc_pkg::status_change_bit, change);
   check_bit("change", 1'b0, change);
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h00);
   wait_ticks(2);
   read_status_bit(openadc_pkg::status_change_bit, change);
   check_bit("change", 1'b0, change);
endtask

task automatic test_led_select();
   logic prev;
   logic change;
   int   len;
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h00); // normal
   @(negedge clk_usb);
   prev = led_armed_o;
   while (led_armed_o === prev)
      @(negedge clk_usb); // line up with a heartbeat edge
   repeat (2) begin
      prev = led_armed_o;
      len  = 0;
      while (led_armed_o === prev) begin
         check_bit("led_capture_o", 1'b0, led_capture_o);
         @(negedge clk_usb);
         len++;
      end
      check_count("heartbeat half period", hb_half, len);
   end
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h01); // heartbeat pair
   repeat (hb_half) begin
      @(negedge clk_usb);
      check_bit("led_capture_o", ~led_armed_o, led_capture_o);
   end
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h02); // flash
   repeat (hb_half) begin
      @(negedge clk_usb);
      check_bit("led_capture_o", led_armed_o, led_capture_o);
   end
   // change select, flag set by a period step with the limit still at 10
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h03);
   set_periods(8, 0);
   wait_ticks(2);
   read_status_bit(openadc_pkg::status_change_bit, change);
   check_bit("change", 1'b1, change);
   repeat (hb_half) begin
      @(negedge clk_usb);
      check_bit("led_capture_o", led_armed_o, led_capture_o);
   end
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h0b); // clears the flag
   reg_write_byte(openadc_pkg::addr_settings, 0, 8'h03);
   repeat (hb_half) begin
      @(negedge clk_usb);
      check_bit("led_capture_o", 1'b0, led_capture_o);
   end
endtask

/* test/openadc_tb.sv */
`timescale 1ns/10ps

module openadc_tb;

   localparam int bytecnt_size  = 7;
   localparam int window_log2   = 10;
   localparam int window_cycles = 1 << window_log2;
   localparam int hb_half       = 2 * window_cycles; // heartbeat half period
   // about 40 windows of test sequence plus margin
   localparam int timeout_cycles = 60000;

   logic                        clk_usb;
   logic                        reset;
   openadc_pkg::reg_addr_t      reg_address_i;
   logic [bytecnt_size-1:0]     reg_bytecnt_i;
   openadc_pkg::reg_byte_t      reg_datai_i;
   logic                        reg_read_i;
   logic                        reg_write_i;
   openadc_pkg::reg_byte_t      reg_datao_o;
   logic                        dut_clk_i;
   logic                        clkgen_i;
   logic                        amp_gain_o;
   logic                        led_armed_o;
   logic                        led_capture_o;

   int          dut_period; // in clk_usb cycles, 0 holds the clock low
   int          gen_period;
   int          dut_phase;
   int          gen_phase;
   int          cycle_count;
   logic [31:0] lcg_state;

   openadc_top #(
      .bytecnt_size (bytecnt_size),
      .window_log2  (window_log2)
   ) dut_i (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .reg_datao_o   (reg_datao_o),
      .dut_clk_i     (dut_clk_i),
      .clkgen_i      (clkgen_i),
      .amp_gain_o    (amp_gain_o),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o)
   );

   always #20 clk_usb = ~clk_usb;

   task automatic report_failure();
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   `include "openadc_tb_tasks.svh"

   function automatic int next_phase(input int phase, input int period);
      return (phase + 1 >= period) ? 0 : phase + 1;
   endfunction

   // measured clocks, square waves counted in whole clk_usb cycles
   always begin
      @(posedge clk_usb);
      #2;
      dut_phase = next_phase(dut_phase, dut_period);
      gen_phase = next_phase(gen_phase, gen_period);
      dut_clk_i = (dut_period > 0) && (dut_phase < dut_period / 2);
      clkgen_i  = (gen_period > 0) && (gen_phase < gen_period / 2);
   end

   always @(posedge clk_usb) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
         report_failure();
      end
   end

   initial begin
      clk_usb       = 1'b0;
      reset         = 1'b1;
      reg_address_i = '0;
      reg_bytecnt_i = '0;
      reg_datai_i   = '0;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      dut_clk_i     = 1'b0;
      clkgen_i      = 1'b0;
      dut_period    = 0;
      gen_period    = 0;
      dut_phase     = 0;
      gen_phase     = 0;
      cycle_count   = 0;
      lcg_state     = 32'hed7e9a7e;

      repeat (10) @(posedge clk_usb);
      #2;
      reset = 1'b0;

      test_reset_readback();
      test_gain_pwm();
      test_freq_measure();
      test_change_detect();
      test_led_select();

      $display("all tests passed");
      $finish;
   end

endmodule

/* openadc.f */
+incdir+test
hdl/openadc_pkg.sv
hdl/clk_monitor_if.sv
hdl/openadc_regs.sv
hdl/status_leds.sv
hdl/clk_monitor.sv
hdl/openadc_top.sv
test/openadc_tb.sv
